//--- verilog/aud_config.svh
`ifndef AUD_CONFIG_SVH
`define AUD_CONFIG_SVH

// one pcm sample, left channel only
`define AUD_SAMPLE_W 16

// sram word address, one sample per word
`define AUD_ADDR_W 20

// playback speed factor
`define AUD_SPEED_W 3

// samples per recording
// kept small for simulation, can go up to the full address range
`define AUD_REC_DEPTH 64

`endif

//--- verilog/audio_pkg.sv
`default_nettype none

`include "aud_config.svh"

package audio_pkg;

	// signed pcm sample as sent by the codec
	typedef logic signed [`AUD_SAMPLE_W-1:0] sample_t;

	// sample address in external sram
	typedef logic [`AUD_ADDR_W-1:0] sram_addr_t;

	// playback factor 1..7, zero counts as 1
	typedef logic [`AUD_SPEED_W-1:0] speed_t;

endpackage

`default_nettype wire

//--- verilog/ctrl_pkg.sv
`default_nettype none

`include "aud_config.svh"

package ctrl_pkg;

	// controller states
	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		RECD       = 3'd1,
		RECD_PAUSE = 3'd2,
		PLAY       = 3'd3,
		PLAY_PAUSE = 3'd4
	} ctrl_state_e;

	// recorder command levels
	typedef struct packed {
		logic start;
		logic pause;
		logic stop;
	} rec_cmd_t;

	// dsp command levels
	typedef struct packed {
		logic start;
		logic pause;
		logic stop;
	} play_cmd_t;

	// playback mode from the user switches
	typedef struct packed {
		audio_pkg::speed_t speed;
		logic              fast;
		logic              slow;
	} play_mode_t;

endpackage

`default_nettype wire

//--- verilog/rec_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module rec_ctrl (
	input  wire                   i_clk,
	input  wire                   i_rst_n,
	input  wire                   i_key_rec,
	input  wire                   i_key_play,
	input  wire                   i_key_stop,
	input  wire                   i_rec_fin,
	input  wire                   i_play_fin,
	output ctrl_pkg::rec_cmd_t    o_rec_cmd,
	output ctrl_pkg::play_cmd_t   o_play_cmd,
	output ctrl_pkg::ctrl_state_e o_state
);

	localparam ctrl_pkg::rec_cmd_t REC_START = '{start: 1'b1, default: 1'b0};
	localparam ctrl_pkg::rec_cmd_t REC_PAUSE = '{pause: 1'b1, default: 1'b0};
	localparam ctrl_pkg::rec_cmd_t REC_STOP  = '{stop: 1'b1, default: 1'b0};

	localparam ctrl_pkg::play_cmd_t PLAY_START = '{start: 1'b1, default: 1'b0};
	localparam ctrl_pkg::play_cmd_t PLAY_PAUSE = '{pause: 1'b1, default: 1'b0};
	localparam ctrl_pkg::play_cmd_t PLAY_STOP  = '{stop: 1'b1, default: 1'b0};

	ctrl_pkg::ctrl_state_e state_q, state_d;
	ctrl_pkg::rec_cmd_t    rec_q, rec_d;
	ctrl_pkg::play_cmd_t   play_q, play_d;

	// keys that do not apply in a state fall through and are ignored
	always_comb begin
		state_d = state_q;
		rec_d   = rec_q;
		play_d  = play_q;
		case (state_q)
			ctrl_pkg::IDLE: begin
				if (i_key_rec) begin
					state_d = ctrl_pkg::RECD;
					rec_d   = REC_START;
					play_d  = '0;
				end else if (i_key_play) begin
					state_d = ctrl_pkg::PLAY;
					play_d  = PLAY_START;
					rec_d   = '0;
				end
			end
			ctrl_pkg::RECD: begin
				if (i_key_stop || i_rec_fin) begin
					state_d = ctrl_pkg::IDLE;
					rec_d   = REC_STOP;
				end else if (i_key_rec) begin
					state_d = ctrl_pkg::RECD_PAUSE;
					rec_d   = REC_PAUSE;
				end
			end
			ctrl_pkg::RECD_PAUSE: begin
				if (i_key_stop) begin
					state_d = ctrl_pkg::IDLE;
					rec_d   = REC_STOP;
				end else if (i_key_rec) begin
					state_d = ctrl_pkg::RECD;
					rec_d   = REC_START;
				end
			end
			ctrl_pkg::PLAY: begin
				if (i_key_stop || i_play_fin) begin
					state_d = ctrl_pkg::IDLE;
					play_d  = PLAY_STOP;
				end else if (i_key_play) begin
					state_d = ctrl_pkg::PLAY_PAUSE;
					play_d  = PLAY_PAUSE;
				end
			end
			ctrl_pkg::PLAY_PAUSE: begin
				if (i_key_stop) begin
					state_d = ctrl_pkg::IDLE;
					play_d  = PLAY_STOP;
				end else if (i_key_play) begin
					state_d = ctrl_pkg::PLAY;
					play_d  = PLAY_START;
				end
			end
			default: begin
				state_d = ctrl_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q <= ctrl_pkg::IDLE;
			rec_q   <= '0;
			play_q  <= '0;
		end else begin
			state_q <= state_d;
			rec_q   <= rec_d;
			play_q  <= play_d;
		end
	end

	assign o_state    = state_q;
	assign o_rec_cmd  = rec_q;
	assign o_play_cmd = play_q;

	// recorder and dsp each see one command level at a time
	a_cmd_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$onehot0(rec_q) && $onehot0(play_q))
		else $error("command struct with more than one level high");

endmodule

`default_nettype wire

//--- verilog/aud_recorder.sv
`timescale 1ns/100ps
`default_nettype none

`include "aud_config.svh"

module aud_recorder (
	input  wire                   i_clk,
	input  wire                   i_rst_n,
	input  wire ctrl_pkg::rec_cmd_t i_cmd,
	input  wire                   i_bclk,
	input  wire                   i_lrck,
	input  wire                   i_adcdat,
	output audio_pkg::sram_addr_t o_addr,
	output audio_pkg::sample_t    o_data,
	output logic                  o_we,
	output audio_pkg::sram_addr_t o_end_addr,
	output logic                  o_fin
);

	localparam audio_pkg::sram_addr_t DEPTH = audio_pkg::sram_addr_t'(`AUD_REC_DEPTH);
	localparam audio_pkg::sram_addr_t LAST_ADDR = DEPTH - 1'b1;
	// rise 0 is the i2s delay bit, rises 1..16 carry msb to lsb
	localparam int CNT_W = $clog2(`AUD_SAMPLE_W + 1);
	localparam logic [CNT_W-1:0] LAST_RISE = CNT_W'(`AUD_SAMPLE_W);

	logic [2:0] bclk_sync;
	logic [2:0] lrck_sync;
	logic [1:0] dat_sync;
	logic bclk_rise;
	logic lrck_fall;
	logic frame_on;
	logic [CNT_W-1:0] rise_cnt;
	logic prev_start;
	logic prev_pause;
	logic from_idle;
	logic full;
	audio_pkg::sram_addr_t addr_q;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bclk_sync <= '0;
			lrck_sync <= '0;
			dat_sync  <= '0;
		end else begin
			bclk_sync <= {bclk_sync[1:0], i_bclk};
			lrck_sync <= {lrck_sync[1:0], i_lrck};
			dat_sync  <= {dat_sync[0], i_adcdat};
		end
	end

	// dat_sync[1] lines up with bclk_sync[1]
	assign bclk_rise = bclk_sync[1] & ~bclk_sync[2];
	assign lrck_fall = ~lrck_sync[1] & lrck_sync[2];

	assign from_idle = i_cmd.start & ~prev_start & ~prev_pause;
	assign full      = (addr_q >= DEPTH);

	// left word capture, dropped when start goes away mid-frame
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			frame_on <= 1'b0;
			rise_cnt <= '0;
			o_we     <= 1'b0;
		end else begin
			o_we <= 1'b0;
			if (!i_cmd.start || full) begin
				frame_on <= 1'b0;
			end else if (lrck_fall) begin
				frame_on <= 1'b1;
				rise_cnt <= '0;
			end else if (frame_on && bclk_rise) begin
				rise_cnt <= rise_cnt + 1'b1;
				if (rise_cnt == LAST_RISE) begin
					frame_on <= 1'b0;
					o_we     <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (frame_on && bclk_rise && rise_cnt != '0) begin
			o_data <= {o_data[`AUD_SAMPLE_W-2:0], dat_sync[1]};
		end
	end

	// address counts written samples, cleared only on a fresh start
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			addr_q     <= '0;
			prev_start <= 1'b0;
			prev_pause <= 1'b0;
			o_fin      <= 1'b0;
		end else begin
			prev_start <= i_cmd.start;
			prev_pause <= i_cmd.pause;
			o_fin      <= o_we && (addr_q == LAST_ADDR);
			if (from_idle) begin
				addr_q <= '0;
			end else if (o_we) begin
				addr_q <= addr_q + 1'b1;
			end
		end
	end

	assign o_addr     = addr_q;
	assign o_end_addr = addr_q;

	a_no_write_past_depth: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_we && full))
		else $error("sram write at or beyond recording depth");

endmodule

`default_nettype wire

//--- verilog/aud_dsp.sv
`timescale 1ns/100ps
`default_nettype none

module aud_dsp (
	input  wire                          i_clk,
	input  wire                          i_rst_n,
	input  wire ctrl_pkg::play_cmd_t     i_cmd,
	input  wire ctrl_pkg::play_mode_t    i_mode,
	input  wire                          i_lrck,
	input  wire audio_pkg::sample_t      i_rdata,
	input  wire audio_pkg::sram_addr_t   i_stop_addr,
	output audio_pkg::sram_addr_t        o_addr,
	output audio_pkg::sample_t           o_sample,
	output logic                         o_active,
	output logic                         o_fin
);

	logic [2:0] lrck_sync;
	logic lrck_fall;
	logic at_end;
	logic hold_done;
	audio_pkg::speed_t step;
	audio_pkg::speed_t hold_q;
	audio_pkg::sram_addr_t addr_q;
	audio_pkg::sram_addr_t addr_next;
	audio_pkg::sample_t sample_q;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lrck_sync <= '0;
		end else begin
			lrck_sync <= {lrck_sync[1:0], i_lrck};
		end
	end

	assign lrck_fall = ~lrck_sync[1] & lrck_sync[2];

	// speed of zero behaves as one
	assign step = (i_mode.speed == '0) ? audio_pkg::speed_t'(1) : i_mode.speed;

	// this output is the last repeat of the held address
	assign hold_done = (hold_q + 1'b1 >= step);

	// fin waits one frame so the last word still reaches the dac
	assign at_end = (addr_q >= i_stop_addr);

	always_comb begin
		addr_next = addr_q + 1'b1;
		if (i_mode.fast) begin
			addr_next = addr_q + step;
		end else if (i_mode.slow && !hold_done) begin
			addr_next = addr_q;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			addr_q   <= '0;
			hold_q   <= '0;
			sample_q <= '0;
			o_fin    <= 1'b0;
		end else begin
			o_fin <= 1'b0;
			if (!i_cmd.start) begin
				sample_q <= '0;
			end
			if (i_cmd.stop) begin
				addr_q <= '0;
				hold_q <= '0;
			end else if (i_cmd.start && lrck_fall) begin
				if (at_end) begin
					o_fin    <= 1'b1;
					sample_q <= '0;
				end else begin
					sample_q <= i_rdata;
					addr_q   <= addr_next;
					if (i_mode.slow && !i_mode.fast && !hold_done) begin
						hold_q <= hold_q + 1'b1;
					end else begin
						hold_q <= '0;
					end
				end
			end
		end
	end

	assign o_addr   = addr_q;
	assign o_sample = sample_q;
	assign o_active = i_cmd.start;

	a_fin_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_fin |=> !o_fin)
		else $error("play finish held longer than one cycle");

endmodule

`default_nettype wire

//--- verilog/aud_player.sv
`timescale 1ns/100ps
`default_nettype none

`include "aud_config.svh"

module aud_player (
	input  wire                     i_clk,
	input  wire                     i_rst_n,
	input  wire                     i_en,
	input  wire                     i_bclk,
	input  wire                     i_lrck,
	input  wire audio_pkg::sample_t i_sample,
	output logic                    o_dacdat
);

	localparam int CNT_W = $clog2(`AUD_SAMPLE_W + 1);

	logic [2:0] bclk_sync;
	logic [2:0] lrck_sync;
	logic bclk_fall;
	logic lrck_fall;
	logic pending;
	logic load;
	logic [CNT_W-1:0] bits_left;
	audio_pkg::sample_t shift_q;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bclk_sync <= '0;
			lrck_sync <= '0;
		end else begin
			bclk_sync <= {bclk_sync[1:0], i_bclk};
			lrck_sync <= {lrck_sync[1:0], i_lrck};
		end
	end

	assign bclk_fall = ~bclk_sync[1] & bclk_sync[2];
	assign lrck_fall = ~lrck_sync[1] & lrck_sync[2];

	// msb goes out one bclk after the frame edge
	assign load = bclk_fall & pending & ~lrck_fall;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pending   <= 1'b0;
			bits_left <= '0;
		end else begin
			if (lrck_fall) begin
				pending <= 1'b1;
			end else if (load) begin
				pending   <= 1'b0;
				bits_left <= CNT_W'(`AUD_SAMPLE_W);
			end else if (bclk_fall && bits_left != '0) begin
				bits_left <= bits_left - 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (load) begin
			shift_q <= i_sample;
		end else if (bclk_fall) begin
			shift_q <= shift_q << 1;
		end
	end

	// zero outside the word, right channel included
	assign o_dacdat = i_en & (bits_left != '0) & shift_q[`AUD_SAMPLE_W-1];

	a_word_fits_frame: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		lrck_fall |-> bits_left == '0)
		else $error("dac word still shifting at next frame start");

endmodule

`default_nettype wire

//--- verilog/aud_top.sv
`timescale 1ns/100ps
`default_nettype none

module aud_top (
	input  wire                        i_clk,
	input  wire                        i_rst_n,
	input  wire                        i_key_rec,
	input  wire                        i_key_play,
	input  wire                        i_key_stop,
	input  wire                        i_aud_bclk,
	input  wire                        i_aud_lrck,
	input  wire                        i_aud_adcdat,
	output logic                       o_aud_dacdat,
	output audio_pkg::sram_addr_t      o_sram_addr,
	output logic                       o_sram_we_n,
	output audio_pkg::sample_t         o_sram_wdata,
	input  wire audio_pkg::sample_t    i_sram_rdata,
	input  wire audio_pkg::speed_t     i_speed,
	input  wire                        i_fast,
	input  wire                        i_slow,
	output ctrl_pkg::ctrl_state_e      o_state
);

	ctrl_pkg::rec_cmd_t    rec_cmd;
	ctrl_pkg::play_cmd_t   play_cmd;
	ctrl_pkg::play_mode_t  play_mode;
	ctrl_pkg::ctrl_state_e state;
	audio_pkg::sram_addr_t rec_addr;
	audio_pkg::sram_addr_t rec_end_addr;
	audio_pkg::sram_addr_t dsp_addr;
	audio_pkg::sample_t    play_sample;
	logic rec_we;
	logic rec_fin;
	logic play_fin;
	logic play_active;
	logic recording;

	assign play_mode = '{speed: i_speed, fast: i_fast, slow: i_slow};

	// sram belongs to the recorder only while recording
	assign recording   = (state == ctrl_pkg::RECD);
	assign o_sram_addr = recording ? rec_addr : dsp_addr;
	assign o_sram_we_n = ~(recording & rec_we);
	assign o_state     = state;

	rec_ctrl u_ctrl (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_key_rec  (i_key_rec),
		.i_key_play (i_key_play),
		.i_key_stop (i_key_stop),
		.i_rec_fin  (rec_fin),
		.i_play_fin (play_fin),
		.o_rec_cmd  (rec_cmd),
		.o_play_cmd (play_cmd),
		.o_state    (state)
	);

	aud_recorder u_recorder (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_cmd      (rec_cmd),
		.i_bclk     (i_aud_bclk),
		.i_lrck     (i_aud_lrck),
		.i_adcdat   (i_aud_adcdat),
		.o_addr     (rec_addr),
		.o_data     (o_sram_wdata),
		.o_we       (rec_we),
		.o_end_addr (rec_end_addr),
		.o_fin      (rec_fin)
	);

	aud_dsp u_dsp (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_cmd       (play_cmd),
		.i_mode      (play_mode),
		.i_lrck      (i_aud_lrck),
		.i_rdata     (i_sram_rdata),
		.i_stop_addr (rec_end_addr),
		.o_addr      (dsp_addr),
		.o_sample    (play_sample),
		.o_active    (play_active),
		.o_fin       (play_fin)
	);

	aud_player u_player (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_en     (play_active),
		.i_bclk   (i_aud_bclk),
		.i_lrck   (i_aud_lrck),
		.i_sample (play_sample),
		.o_dacdat (o_aud_dacdat)
	);

endmodule

`default_nettype wire

//--- testbench/aud_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "aud_config.svh"

module aud_tb;

	localparam int KEY_REC  = 0;
	localparam int KEY_PLAY = 1;
	localparam int KEY_STOP = 2;
	localparam int DEPTH    = `AUD_REC_DEPTH;

	logic clk;
	logic rst_n;
	logic key_rec;
	logic key_play;
	logic key_stop;
	logic bclk;
	logic lrck;
	logic adcdat;
	logic dacdat;
	logic sram_we_n;
	logic fast;
	logic slow;
	audio_pkg::speed_t     speed;
	audio_pkg::sram_addr_t sram_addr;
	audio_pkg::sample_t    sram_wdata;
	audio_pkg::sample_t    sram_rdata;
	ctrl_pkg::ctrl_state_e state;

	audio_pkg::sample_t mem [0:(1 << `AUD_ADDR_W) - 1];
	logic [31:0] cases_mem [0:511];

	// codec timing, 4 clocks per bclk and 32 bclks per frame
	logic [6:0] cnt;
	logic [6:0] cnt_n;
	logic [4:0] bit_slot;
	audio_pkg::sample_t adc_word;
	audio_pkg::sample_t cur_word;

	// model of the controller and playback
	ctrl_pkg::ctrl_state_e ms;
	audio_pkg::sample_t    exp_q[$];
	audio_pkg::sram_addr_t pa;
	audio_pkg::speed_t     ph;
	audio_pkg::speed_t     spd;
	logic f_fast;
	logic f_slow;
	logic rec_mode;
	int pc;
	integer seed;
	longint limit_ns;

	aud_top dut (
		.i_clk        (clk),
		.i_rst_n      (rst_n),
		.i_key_rec    (key_rec),
		.i_key_play   (key_play),
		.i_key_stop   (key_stop),
		.i_aud_bclk   (bclk),
		.i_aud_lrck   (lrck),
		.i_aud_adcdat (adcdat),
		.o_aud_dacdat (dacdat),
		.o_sram_addr  (sram_addr),
		.o_sram_we_n  (sram_we_n),
		.o_sram_wdata (sram_wdata),
		.i_sram_rdata (sram_rdata),
		.i_speed      (speed),
		.i_fast       (fast),
		.i_slow       (slow),
		.o_state      (state)
	);

	always #50 clk = ~clk;

	// asynchronous sram, read in the same cycle
	assign sram_rdata = mem[sram_addr];

	always @(posedge clk) begin
		if (!sram_we_n) begin
			mem[sram_addr] <= sram_wdata;
		end
	end

	assign cnt_n    = cnt + 7'd1;
	assign bit_slot = cnt_n[6:2];

	// left half starts at the lrck fall, msb one bclk later
	always @(posedge clk) begin
		cnt  <= cnt_n;
		bclk <= cnt_n[1];
		lrck <= cnt_n[6];
		if (cnt_n == 7'd0) begin
			cur_word <= adc_word;
		end
		if (bit_slot >= 5'd1 && bit_slot <= 5'd16) begin
			adcdat <= cur_word[5'd16 - bit_slot];
		end else begin
			adcdat <= 1'b0;
		end
	end

	function automatic audio_pkg::sample_t fill_word(input audio_pkg::sram_addr_t a);
		return a[15:0] ^ {12'h000, a[19:16]} ^ 16'hc3a5;
	endfunction

	function automatic audio_pkg::sample_t rand_word();
		audio_pkg::sample_t w;
		w = audio_pkg::sample_t'($random(seed));
		return w | 16'h0001;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_sample(input audio_pkg::sample_t got, input audio_pkg::sample_t exp,
			input string what);
		if (got !== exp) begin
			$display("ERR %0t ns %s: got %h, expected %h", $time, what, got, exp);
			abort_run("sample mismatch");
		end
	endtask

	task automatic check_addr(input audio_pkg::sram_addr_t got,
			input audio_pkg::sram_addr_t exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t ns %s: got %h, expected %h", $time, what, got, exp);
			abort_run("address mismatch");
		end
	endtask

	task automatic check_state(input ctrl_pkg::ctrl_state_e got,
			input ctrl_pkg::ctrl_state_e exp);
		if (got !== exp) begin
			$display("ERR %0t ns state: got %s, expected %s", $time, got.name(), exp.name());
			abort_run("state mismatch");
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t ns %s: got %b, expected %b", $time, what, got, exp);
			abort_run("level mismatch");
		end
	endtask

	task automatic wait_cnt(input int v);
		@(negedge clk);
		while (cnt != 7'(v)) @(negedge clk);
	endtask

	// keys only in the right half of a frame
	task automatic press_key(input int which);
		@(negedge clk);
		while (cnt < 7'd72 || cnt > 7'd120) @(negedge clk);
		@(posedge clk);
		key_rec  <= (which == KEY_REC);
		key_play <= (which == KEY_PLAY);
		key_stop <= (which == KEY_STOP);
		@(posedge clk);
		key_rec  <= 1'b0;
		key_play <= 1'b0;
		key_stop <= 1'b0;
	endtask

	// dac bits are sampled in the middle of each bclk period
	task automatic read_word(output audio_pkg::sample_t w);
		w = '0;
		for (int j = 1; j <= 16; j++) begin
			wait_cnt(4 * j + 5);
			w = {w[14:0], dacdat};
		end
	endtask

	task automatic record_frames(input logic use_rand, input int n);
		audio_pkg::sample_t w;
		for (int i = 0; i < n; i++) begin
			if (use_rand) begin
				w = rand_word();
			end else begin
				w = audio_pkg::sample_t'(cases_mem[pc]);
				pc++;
			end
			adc_word = w;
			wait_cnt(10);
			wait_cnt(100);
			if (ms == ctrl_pkg::RECD && exp_q.size() < DEPTH) begin
				exp_q.push_back(w);
				if (exp_q.size() == DEPTH) begin
					ms = ctrl_pkg::IDLE;
				end
			end
			check_state(state, ms);
		end
	endtask

	task automatic idle_frames(input int n);
		audio_pkg::sample_t w;
		for (int i = 0; i < n; i++) begin
			adc_word = rand_word();
			read_word(w);
			check_sample(w, '0, "dac word while not playing");
			check_state(state, ms);
		end
	endtask

	task automatic play_frames(input int n);
		audio_pkg::sample_t w;
		audio_pkg::speed_t step;
		for (int i = 0; i < n && ms == ctrl_pkg::PLAY; i++) begin
			step = (spd == '0) ? 3'd1 : spd;
			read_word(w);
			if (pa >= audio_pkg::sram_addr_t'(exp_q.size())) begin
				check_sample(w, '0, "dac word after the recorded end");
				ms = ctrl_pkg::IDLE;
				pa = '0;
				ph = '0;
			end else begin
				check_sample(w, exp_q[pa], "dac word");
				if (f_fast) begin
					pa = pa + step;
					ph = '0;
				end else if (f_slow && ph + 3'd1 < step) begin
					ph = ph + 3'd1;
				end else begin
					pa = pa + 1'b1;
					ph = '0;
				end
				check_addr(sram_addr, pa, "playback address");
			end
			check_state(state, ms);
		end
	endtask

	task automatic stop_and_check();
		press_key(KEY_STOP);
		repeat (3) @(negedge clk);
		ms = ctrl_pkg::IDLE;
		check_state(state, ms);
		if (rec_mode) begin
			for (int i = 0; i < exp_q.size(); i++) begin
				check_sample(mem[i], exp_q[i], "recorded sample");
			end
			for (int a = DEPTH; a < DEPTH + 4; a++) begin
				check_sample(mem[a], fill_word(a), "sram beyond the depth");
			end
		end
		pa = '0;
		ph = '0;
	endtask

	// sums frames so the watchdog scales with the cases
	task automatic scan_cases();
		longint frames;
		int p;
		logic rflag;
		frames = 20;
		p = 0;
		rflag = 1'b0;
		while (cases_mem[p] != 32'd0) begin
			if (cases_mem[p] == 32'd1 || cases_mem[p] == 32'd7) begin
				rflag = 1'b1;
			end else if (cases_mem[p] == 32'd5) begin
				rflag = 1'b0;
			end
			frames += cases_mem[p + 4] + 4;
			if (cases_mem[p] == 32'd1 || (cases_mem[p] == 32'd3 && rflag)) begin
				p += 5 + int'(cases_mem[p + 4]);
			end else begin
				p += 5;
			end
		end
		limit_ns = frames * 128 * 100;
	endtask

	initial begin
		wait (limit_ns != 0);
		#(limit_ns);
		abort_run("timeout: the run did not finish in time");
	end

	initial begin
		int op;
		int frames;
		clk       = 1'b0;
		rst_n     = 1'b0;
		key_rec   = 1'b0;
		key_play  = 1'b0;
		key_stop  = 1'b0;
		bclk      = 1'b0;
		lrck      = 1'b0;
		adcdat    = 1'b0;
		speed     = 3'd1;
		fast      = 1'b0;
		slow      = 1'b0;
		cnt       = 7'd0;
		adc_word  = 16'h0001;
		cur_word  = 16'h0001;
		seed      = 32'hbf5d;
		ms        = ctrl_pkg::IDLE;
		rec_mode  = 1'b0;
		pa        = '0;
		ph        = '0;
		spd       = 3'd1;
		f_fast    = 1'b0;
		f_slow    = 1'b0;
		for (int a = 0; a < (1 << `AUD_ADDR_W); a++) begin
			mem[a] = fill_word(a);
		end
		$readmemh("testbench/aud_cases.txt", cases_mem);
		scan_cases();

		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_state(state, ctrl_pkg::IDLE);
		check_bit(sram_we_n, 1'b1, "sram write enable after reset");
		check_bit(dacdat, 1'b0, "dac line after reset");
		check_addr(sram_addr, '0, "sram address after reset");

		pc = 0;
		while (cases_mem[pc] != 32'd0) begin
			op     = int'(cases_mem[pc]);
			spd    = audio_pkg::speed_t'(cases_mem[pc + 1]);
			f_fast = cases_mem[pc + 2][0];
			f_slow = cases_mem[pc + 3][0];
			frames = int'(cases_mem[pc + 4]);
			pc += 5;
			@(posedge clk);
			speed <= spd;
			fast  <= f_fast;
			slow  <= f_slow;
			case (op)
				1, 7: begin
					press_key(KEY_REC);
					ms       = ctrl_pkg::RECD;
					rec_mode = 1'b1;
					exp_q.delete();
					record_frames(op == 7, frames);
				end
				2: begin
					press_key(rec_mode ? KEY_REC : KEY_PLAY);
					ms = rec_mode ? ctrl_pkg::RECD_PAUSE : ctrl_pkg::PLAY_PAUSE;
					idle_frames(frames);
				end
				3: begin
					press_key(rec_mode ? KEY_REC : KEY_PLAY);
					ms = rec_mode ? ctrl_pkg::RECD : ctrl_pkg::PLAY;
					if (rec_mode) begin
						record_frames(1'b0, frames);
					end else begin
						play_frames(frames);
					end
				end
				4: stop_and_check();
				5: begin
					press_key(KEY_PLAY);
					ms       = ctrl_pkg::PLAY;
					rec_mode = 1'b0;
					play_frames(frames);
				end
				6: idle_frames(frames);
				default: abort_run("unknown operation in the cases file");
			endcase
		end

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/aud_cases.txt
// op speed fast slow frames, then one sample word per frame for op 1 and for op 3 while recording
// ops: 1 record, 2 pause, 3 resume, 4 stop, 5 play, 6 wait, 7 record random words, 0 end
7 1 0 0 44
4 1 0 0 0
1 1 0 0 4 1234 8001 7fff 0a5c
4 1 0 0 0
1 1 0 0 3 1111 2222 3333
2 1 0 0 2
3 1 0 0 3 4444 5555 6666
4 1 0 0 0
5 1 0 0 8
6 1 0 0 1
5 2 1 0 5
5 3 0 1 5
2 3 0 1 2
3 3 0 1 4
4 3 0 1 0
0 0 0 0 0

//--- tb.f
+incdir+verilog
verilog/audio_pkg.sv
verilog/ctrl_pkg.sv
verilog/rec_ctrl.sv
verilog/aud_recorder.sv
verilog/aud_dsp.sv
verilog/aud_player.sv
verilog/aud_top.sv
testbench/aud_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module aud_tb -o sim_aud
out=$(./obj_dir/sim_aud 2>&1 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '** PASS **'
